// ==== Bender.yml ====
package:
  name: mem_stage

sources:
  - include_dirs:
      - design
    files:
      - design/mem_op_pkg.sv
      - design/mem_bus_pkg.sv
      - design/cache_lookup_if.sv
      - design/mem_request_decode.sv
      - design/cache_way.sv
      - design/load_align.sv
      - design/mem_access_fsm.sv
      - design/mem_stage_top.sv
  - target: test
    files:
      - tests/mem_stage_tb.sv

// ==== design/cache_lookup_if.sv ====
`timescale 1ns/1ps
`include "mem_stage_settings.svh"

interface cache_lookup_if;

    logic [`MEM_INDEX_W-1:0]    index;
    logic [`MEM_TAG_W-1:0]      tag;
    logic                       is_load;
    logic                       is_store;
    logic                       cached;
    // Store payload already shifted into its byte lanes
    logic [`MEM_DATA_W/8-1:0]   store_strb;
    logic [`MEM_DATA_W-1:0]     store_data;

    modport decoder (
        output index, tag, is_load, is_store, cached, store_strb, store_data
    );

    modport way (
        input index, tag, store_strb, store_data
    );

    modport ctrl (
        input is_load, is_store, cached
    );

endinterface

// ==== design/cache_way.sv ====
`timescale 1ns/1ps
`include "mem_stage_settings.svh"

module cache_way (
    input  logic                    clk,
    input  logic                    rst,
    cache_lookup_if.way             lookup,
    input  logic                    fill_en,
    input  logic                    store_upd,
    input  logic [`MEM_DATA_W-1:0]  fill_data,
    output logic                    hit,
    output logic                    valid,
    output logic [`MEM_DATA_W-1:0]  rdata
);

    logic [`MEM_NUM_SETS-1:0]   valid_q;
    logic [`MEM_TAG_W-1:0]      tag_q [`MEM_NUM_SETS];
    logic [`MEM_DATA_W-1:0]     data_q [`MEM_NUM_SETS];

    // Lookup of the addressed set
    assign valid = valid_q[lookup.index];
    assign hit = valid && (tag_q[lookup.index] == lookup.tag);
    assign rdata = data_q[lookup.index];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
        end else if (fill_en) begin
            valid_q[lookup.index] <= 1'b1;
        end
    end

    // Fill replaces the whole word; store merges byte lanes on a hit
    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_q[lookup.index] <= lookup.tag;
            data_q[lookup.index] <= fill_data;
        end else if (store_upd && hit) begin
            for (int b = 0; b < `MEM_DATA_W/8; b++) begin
                if (lookup.store_strb[b]) begin
                    data_q[lookup.index][8*b +: 8] <= lookup.store_data[8*b +: 8];
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) !(fill_en && store_upd));

endmodule

// ==== design/load_align.sv ====
`timescale 1ns/1ps
`include "mem_stage_settings.svh"

module load_align (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    bus_capture,
    input  logic [`MEM_DATA_W-1:0]  r_data,
    input  logic                    cached,
    input  logic [`MEM_NUM_WAYS-1:0] hit_vec,
    input  logic [`MEM_DATA_W-1:0]  way_rdata [`MEM_NUM_WAYS],
    input  mem_op_pkg::mem_op_e     op,
    input  logic [2:0]              offset,
    output logic [`MEM_DATA_W-1:0]  bus_word,
    output logic [`MEM_DATA_W-1:0]  resp_data
);
    import mem_op_pkg::*;

    logic [`MEM_DATA_W-1:0] word;
    logic [`MEM_DATA_W-1:0] shifted;

    // Last R beat, also the fill word for the ways
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bus_word <= '0;
        end else if (bus_capture) begin
            bus_word <= r_data;
        end
    end

    always_comb begin
        word = cached ? '0 : bus_word;
        for (int w = 0; w < `MEM_NUM_WAYS; w++) begin
            if (cached && hit_vec[w]) begin
                word = way_rdata[w];
            end
        end
    end

    assign shifted = word >> {offset, 3'b000};

    always_comb begin
        case (op)
            OP_LB:   resp_data = {{56{shifted[7]}}, shifted[7:0]};
            OP_LH:   resp_data = {{48{shifted[15]}}, shifted[15:0]};
            OP_LW:   resp_data = {{32{shifted[31]}}, shifted[31:0]};
            OP_LD:   resp_data = shifted;
            OP_LBU:  resp_data = {56'd0, shifted[7:0]};
            OP_LHU:  resp_data = {48'd0, shifted[15:0]};
            OP_LWU:  resp_data = {32'd0, shifted[31:0]};
            default: resp_data = '0;
        endcase
    end

endmodule

// ==== design/mem_access_fsm.sv ====
`timescale 1ns/1ps
`include "mem_stage_settings.svh"

module mem_access_fsm (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        req_valid,
    input  mem_op_pkg::mem_op_e         op,
    cache_lookup_if.ctrl                lookup,
    input  logic [`MEM_NUM_WAYS-1:0]    hit_vec,
    input  logic [`MEM_NUM_WAYS-1:0]    valid_vec,
    output logic [`MEM_NUM_WAYS-1:0]    fill_en,
    output logic                        store_upd,
    output logic                        bus_capture,
    output logic                        ar_valid,
    input  logic                        ar_ready,
    input  logic                        r_valid,
    output logic                        r_ready,
    output logic                        aw_valid,
    input  logic                        aw_ready,
    output logic                        w_valid,
    input  logic                        w_ready,
    input  logic                        b_valid,
    output logic                        b_ready,
    output logic                        resp_valid
);
    import mem_op_pkg::*;
    import mem_bus_pkg::*;

    mem_state_e                 state;
    mem_state_e                 state_next;
    logic                       hit_any;
    logic                       w_sent;
    logic [`MEM_NUM_WAYS-1:0]   victim;

    assign hit_any = |hit_vec;

    // First invalid way wins, way 0 when the set is full
    always_comb begin
        victim = '0;
        victim[0] = 1'b1;
        for (int w = `MEM_NUM_WAYS - 1; w >= 0; w--) begin
            if (!valid_vec[w]) begin
                victim = '0;
                victim[w] = 1'b1;
            end
        end
    end

    // ######################################################################
    // State sequencing
    // ######################################################################

    always_comb begin
        state_next = state;
        case (state)
            S_IDLE: begin
                if (req_valid && lookup.is_load) begin
                    state_next = (lookup.cached && hit_any) ? S_RD_CACHE : S_RD_ADDR;
                end else if (req_valid && lookup.is_store) begin
                    state_next = S_WR_ADDR;
                end
            end
            S_RD_CACHE: state_next = S_DONE;
            S_RD_ADDR: begin
                if (ar_ready) begin
                    state_next = S_RD_DATA;
                end
            end
            S_RD_DATA: begin
                if (r_valid) begin
                    state_next = lookup.cached ? S_FILL : S_DONE;
                end
            end
            // Loads read the filled way next, stores are finished
            S_FILL: state_next = lookup.is_load ? S_RD_CACHE : S_DONE;
            S_WR_ADDR: begin
                if (aw_ready) begin
                    state_next = S_WR_DATA;
                end
            end
            S_WR_DATA: begin
                if (b_valid && (w_sent || w_ready)) begin
                    state_next = (lookup.cached && hit_any) ? S_FILL : S_DONE;
                end
            end
            default: state_next = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= S_IDLE;
            w_sent <= 1'b0;
        end else begin
            state <= state_next;
            if (state == S_DONE) begin
                w_sent <= 1'b0;
            end else if (w_valid && w_ready) begin
                w_sent <= 1'b1;
            end
        end
    end

    // ######################################################################
    // Outputs decoded from state
    // ######################################################################

    assign ar_valid = (state == S_RD_ADDR);
    assign r_ready = (state == S_RD_DATA);
    assign aw_valid = (state == S_WR_ADDR);
    assign w_valid = (state == S_WR_ADDR) || (state == S_WR_DATA);
    assign b_ready = w_valid;

    assign bus_capture = r_ready && r_valid;
    assign fill_en = (state == S_FILL && lookup.is_load) ? victim : '0;
    assign store_upd = (state == S_FILL) && lookup.is_store;

    // NOP completes in the same cycle it is presented
    assign resp_valid = req_valid && (op == OP_NOP || state == S_DONE);

    // Read address only for loads and write address only for stores
    assert property (@(posedge clk) disable iff (rst)
        !(ar_valid && !lookup.is_load) && !(aw_valid && !lookup.is_store));

    // Request must stay held across the whole access
    assert property (@(posedge clk) disable iff (rst) (state != S_IDLE) |-> req_valid);

endmodule

// ==== design/mem_bus_pkg.sv ====
package mem_bus_pkg;

    typedef enum logic [2:0] {
        S_IDLE,
        S_RD_CACHE,
        S_RD_ADDR,
        S_RD_DATA,
        S_FILL,
        S_WR_ADDR,
        S_WR_DATA,
        S_DONE
    } mem_state_e;

    // AXI AxSIZE encoding
    typedef enum logic [2:0] {
        AXI_SIZE_1 = 3'b000,
        AXI_SIZE_2 = 3'b001,
        AXI_SIZE_4 = 3'b010,
        AXI_SIZE_8 = 3'b011
    } axi_size_e;

endpackage

// ==== design/mem_op_pkg.sv ====
package mem_op_pkg;

    // Opcodes presented by the execute stage
    typedef enum logic [3:0] {
        OP_NOP = 4'd0,
        OP_LB  = 4'd1,
        OP_LH  = 4'd2,
        OP_LW  = 4'd3,
        OP_LD  = 4'd4,
        OP_LBU = 4'd5,
        OP_LHU = 4'd6,
        OP_LWU = 4'd7,
        OP_SB  = 4'd8,
        OP_SH  = 4'd9,
        OP_SW  = 4'd10,
        OP_SD  = 4'd11
    } mem_op_e;

    // Number of bytes touched, as log2
    typedef enum logic [1:0] {
        ACC_BYTE   = 2'd0,
        ACC_HALF   = 2'd1,
        ACC_WORD   = 2'd2,
        ACC_DOUBLE = 2'd3
    } acc_size_e;

endpackage

// ==== design/mem_request_decode.sv ====
`timescale 1ns/1ps
`include "mem_stage_settings.svh"

module mem_request_decode (
    input  logic                    clk,
    input  logic                    rst,
    input  mem_op_pkg::mem_op_e     op,
    input  logic [`MEM_ADDR_W-1:0]  addr,
    input  logic [`MEM_DATA_W-1:0]  wdata,
    cache_lookup_if.decoder         lookup,
    output logic [`MEM_ADDR_W-1:0]  ar_addr,
    output logic [`MEM_ADDR_W-1:0]  aw_addr,
    output mem_bus_pkg::axi_size_e  ar_size,
    output mem_bus_pkg::axi_size_e  aw_size
);
    import mem_op_pkg::*;
    import mem_bus_pkg::*;

    acc_size_e  size;
    logic [2:0] offset;
    logic [2:0] align_mask;
    logic [7:0] base_strb;
    logic       misaligned;

    assign offset = addr[2:0];

    always_comb begin
        lookup.is_load = 1'b0;
        lookup.is_store = 1'b0;
        size = ACC_BYTE;
        case (op)
            OP_LB, OP_LBU: begin
                lookup.is_load = 1'b1;
            end
            OP_LH, OP_LHU: begin
                lookup.is_load = 1'b1;
                size = ACC_HALF;
            end
            OP_LW, OP_LWU: begin
                lookup.is_load = 1'b1;
                size = ACC_WORD;
            end
            OP_LD: begin
                lookup.is_load = 1'b1;
                size = ACC_DOUBLE;
            end
            OP_SB: begin
                lookup.is_store = 1'b1;
            end
            OP_SH: begin
                lookup.is_store = 1'b1;
                size = ACC_HALF;
            end
            OP_SW: begin
                lookup.is_store = 1'b1;
                size = ACC_WORD;
            end
            OP_SD: begin
                lookup.is_store = 1'b1;
                size = ACC_DOUBLE;
            end
            default: begin
                size = ACC_BYTE;
            end
        endcase
    end

    // Address split, cached region is the upper half of the 32-bit space
    assign lookup.index = addr[`MEM_INDEX_W+2:3];
    assign lookup.tag = addr[`MEM_ADDR_W-1:`MEM_INDEX_W+3];
    assign lookup.cached = addr[31];

    // Cached traffic moves whole words
    assign ar_addr = lookup.cached ? {addr[`MEM_ADDR_W-1:3], 3'b000} : addr;
    assign aw_addr = ar_addr;
    assign ar_size = lookup.cached ? AXI_SIZE_8 : axi_size_e'({1'b0, size});
    assign aw_size = ar_size;

    assign align_mask = (3'b001 << size) - 3'b001;
    assign base_strb = (8'h02 << ((4'd1 << size) - 4'd1)) - 8'h01;
    assign misaligned = (offset & align_mask) != 3'b000;

    assign lookup.store_strb = (lookup.is_store && !misaligned) ? base_strb << offset : 8'h00;
    assign lookup.store_data = wdata << {offset, 3'b000};

    // Misaligned stores are trapped in execute and never reach this stage
    assert property (@(posedge clk) disable iff (rst)
        lookup.is_store |-> !misaligned);

endmodule

// ==== design/mem_stage_settings.svh ====
`ifndef MEM_STAGE_SETTINGS_SVH
`define MEM_STAGE_SETTINGS_SVH

// ##########################################################################
// Cache geometry
// ##########################################################################

`define MEM_NUM_WAYS 4
`define MEM_NUM_SETS 16
`define MEM_INDEX_W 4

// ##########################################################################
// Datapath widths
// ##########################################################################

`define MEM_ADDR_W 64
`define MEM_DATA_W 64
// Three low bits select the byte inside a 64-bit word
`define MEM_TAG_W (`MEM_ADDR_W - `MEM_INDEX_W - 3)

`endif

// ==== design/mem_stage_top.sv ====
`timescale 1ns/1ps
`include "mem_stage_settings.svh"

module mem_stage_top (
    input  logic                    clk,
    input  logic                    rst,

    input  logic                    req_valid,
    input  mem_op_pkg::mem_op_e     req_op,
    input  logic [`MEM_ADDR_W-1:0]  req_addr,
    input  logic [`MEM_DATA_W-1:0]  req_wdata,
    output logic                    resp_valid,
    output logic [`MEM_DATA_W-1:0]  resp_data,

    output logic                    ar_valid,
    input  logic                    ar_ready,
    output logic [`MEM_ADDR_W-1:0]  ar_addr,
    output mem_bus_pkg::axi_size_e  ar_size,
    input  logic                    r_valid,
    output logic                    r_ready,
    input  logic [`MEM_DATA_W-1:0]  r_data,
    output logic                    aw_valid,
    input  logic                    aw_ready,
    output logic [`MEM_ADDR_W-1:0]  aw_addr,
    output mem_bus_pkg::axi_size_e  aw_size,
    output logic                    w_valid,
    input  logic                    w_ready,
    output logic [`MEM_DATA_W-1:0]  w_data,
    output logic [`MEM_DATA_W/8-1:0] w_strb,
    input  logic                    b_valid,
    output logic                    b_ready
);

    cache_lookup_if lookup ();

    logic [`MEM_NUM_WAYS-1:0]   hit_vec;
    logic [`MEM_NUM_WAYS-1:0]   valid_vec;
    logic [`MEM_NUM_WAYS-1:0]   fill_en;
    logic [`MEM_DATA_W-1:0]     way_rdata [`MEM_NUM_WAYS];
    logic [`MEM_DATA_W-1:0]     bus_word;
    logic                       store_upd;
    logic                       bus_capture;

    // Store lanes go out on W unchanged
    assign w_data = lookup.store_data;
    assign w_strb = lookup.store_strb;

    mem_request_decode mem_request_decode_inst (
        .clk     (clk),
        .rst     (rst),
        .op      (req_op),
        .addr    (req_addr),
        .wdata   (req_wdata),
        .lookup  (lookup),
        .ar_addr (ar_addr),
        .aw_addr (aw_addr),
        .ar_size (ar_size),
        .aw_size (aw_size)
    );

    for (genvar w = 0; w < `MEM_NUM_WAYS; w++) begin : g_way
        cache_way cache_way_inst (
            .clk       (clk),
            .rst       (rst),
            .lookup    (lookup),
            .fill_en   (fill_en[w]),
            .store_upd (store_upd),
            .fill_data (bus_word),
            .hit       (hit_vec[w]),
            .valid     (valid_vec[w]),
            .rdata     (way_rdata[w])
        );
    end

    load_align load_align_inst (
        .clk         (clk),
        .rst         (rst),
        .bus_capture (bus_capture),
        .r_data      (r_data),
        .cached      (lookup.cached),
        .hit_vec     (hit_vec),
        .way_rdata   (way_rdata),
        .op          (req_op),
        .offset      (req_addr[2:0]),
        .bus_word    (bus_word),
        .resp_data   (resp_data)
    );

    mem_access_fsm mem_access_fsm_inst (
        .clk         (clk),
        .rst         (rst),
        .req_valid   (req_valid),
        .op          (req_op),
        .lookup      (lookup),
        .hit_vec     (hit_vec),
        .valid_vec   (valid_vec),
        .fill_en     (fill_en),
        .store_upd   (store_upd),
        .bus_capture (bus_capture),
        .ar_valid    (ar_valid),
        .ar_ready    (ar_ready),
        .r_valid     (r_valid),
        .r_ready     (r_ready),
        .aw_valid    (aw_valid),
        .aw_ready    (aw_ready),
        .w_valid     (w_valid),
        .w_ready     (w_ready),
        .b_valid     (b_valid),
        .b_ready     (b_ready),
        .resp_valid  (resp_valid)
    );

endmodule

// ==== mem_stage.f ====
+incdir+design
design/mem_op_pkg.sv
design/mem_bus_pkg.sv
design/cache_lookup_if.sv
design/mem_request_decode.sv
design/cache_way.sv
design/load_align.sv
design/mem_access_fsm.sv
design/mem_stage_top.sv
tests/mem_stage_tb.sv

// ==== tests/mem_stage_tb.sv ====
`timescale 1ns/1ps

module mem_stage_tb;
    import mem_op_pkg::*;

    localparam int NUM_REQ = 300;
    localparam int MAX_LAT = 40;
    // Random stores and loads may each add one follow-up request
    localparam int TIMEOUT = (2 * NUM_REQ + 8) * MAX_LAT + 500;

    logic clk = 1'b0;
    logic rst;
    logic req_valid;
    mem_op_e req_op;
    logic [63:0] req_addr;
    logic [63:0] req_wdata;
    logic resp_valid;
    logic [63:0] resp_data;
    logic ar_valid, r_ready, aw_valid, w_valid, b_ready;
    logic ar_ready = 1'b0;
    logic aw_ready = 1'b0;
    logic w_ready = 1'b0;
    logic r_valid = 1'b0;
    logic b_valid = 1'b0;
    logic [63:0] r_data = '0;
    logic [63:0] ar_addr, aw_addr, w_data;
    logic [7:0] w_strb;
    mem_bus_pkg::axi_size_e ar_size, aw_size;

    logic [31:0] stim_lfsr = 32'h6707;
    logic [31:0] bus_lfsr = 32'h6707;
    logic [7:0] mem [longint];
    logic m_valid [16][4];
    logic [56:0] m_tag [16][4];
    int ar_count = 0;
    int aw_count = 0;
    int b_count = 0;
    logic [63:0] ar_addr_seen;
    logic [2:0] ar_size_seen;
    logic [63:0] aw_addr_seen, w_data_seen;
    logic [7:0] w_strb_seen;
    logic [2:0] aw_size_seen;
    int data_errors = 0;
    int proto_errors = 0;
    int cycle_count = 0;

    mem_stage_top mem_stage_top_inst (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int stim_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            stim_lfsr = lfsr_next(stim_lfsr);
            v = (v << 1) | stim_lfsr[0];
        end
        return v;
    endfunction

    function automatic int bus_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            bus_lfsr = lfsr_next(bus_lfsr);
            v = (v << 1) | bus_lfsr[0];
        end
        return v;
    endfunction

    // Untouched bytes fold every address byte together
    function automatic logic [7:0] read_byte(input logic [63:0] a);
        logic [7:0] f;
        f = 8'h5a;
        for (int i = 0; i < 8; i++) begin
            f = f ^ a[8*i +: 8];
        end
        return mem.exists(a) ? mem[a] : f;
    endfunction

    function automatic logic [63:0] read_word(input logic [63:0] a);
        logic [63:0] v;
        for (int i = 0; i < 8; i++) begin
            v[8*i +: 8] = read_byte({a[63:3], 3'b000} + i);
        end
        return v;
    endfunction

    function automatic int op_size(input mem_op_e op);
        case (op)
            OP_LH, OP_LHU, OP_SH: return 1;
            OP_LW, OP_LWU, OP_SW: return 2;
            OP_LD, OP_SD:         return 3;
            default:              return 0;
        endcase
    endfunction

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > TIMEOUT) begin
            $display("Timeout, a request got no response within %0d cycles", TIMEOUT);
            $display("Regression failed");
            $finish;
        end
    end

    // ######################################################################
    // AXI slave model
    // ######################################################################

    logic [63:0] rd_addr, wr_addr, wr_data;
    logic [7:0] wr_strb;
    logic rd_busy, wr_aw, wr_w;
    int rd_wait, b_wait;

    always @(posedge clk) begin
        if (rst) begin
            ar_ready <= 1'b0;
            aw_ready <= 1'b0;
            w_ready <= 1'b0;
            r_valid <= 1'b0;
            b_valid <= 1'b0;
            rd_busy = 1'b0;
            wr_aw = 1'b0;
            wr_w = 1'b0;
        end else begin
            ar_ready <= bus_bits(1);
            aw_ready <= bus_bits(1);
            w_ready <= bus_bits(1);
            if (ar_valid && ar_ready) begin
                rd_addr = ar_addr;
                rd_busy = 1'b1;
                rd_wait = bus_bits(2);
                ar_addr_seen <= ar_addr;
                ar_size_seen <= ar_size;
                ar_count <= ar_count + 1;
            end
            if (r_valid && r_ready) begin
                r_valid <= 1'b0;
            end else if (rd_busy && !r_valid) begin
                if (rd_wait == 0) begin
                    r_valid <= 1'b1;
                    r_data <= read_word(rd_addr);
                    rd_busy = 1'b0;
                end else begin
                    rd_wait--;
                end
            end
            if (aw_valid && aw_ready && !wr_aw) begin
                wr_aw = 1'b1;
                wr_addr = aw_addr;
                b_wait = bus_bits(2);
                aw_addr_seen <= aw_addr;
                aw_size_seen <= aw_size;
                aw_count <= aw_count + 1;
            end
            if (w_valid && w_ready && !wr_w) begin
                wr_w = 1'b1;
                wr_data = w_data;
                wr_strb = w_strb;
                w_data_seen <= w_data;
                w_strb_seen <= w_strb;
            end
            if (b_valid && b_ready) begin
                b_valid <= 1'b0;
                b_count <= b_count + 1;
                wr_aw = 1'b0;
                wr_w = 1'b0;
            end else if (wr_aw && wr_w && !b_valid) begin
                if (b_wait == 0) begin
                    for (int i = 0; i < 8; i++) begin
                        if (wr_strb[i]) begin
                            mem[{wr_addr[63:3], 3'b000} + i] = wr_data[8*i +: 8];
                        end
                    end
                    b_valid <= 1'b1;
                end else begin
                    b_wait--;
                end
            end
        end
    end

    // ######################################################################
    // Request driver with reference cache model
    // ######################################################################

    task automatic run_request(input mem_op_e op, input logic [63:0] addr,
                               input logic [63:0] wdata);
        int size;
        int cycles;
        int ar0, aw0, b0;
        int victim;
        logic cached, hit, is_load, is_store;
        logic [3:0] set;
        logic [56:0] tag;
        logic [63:0] word, exp_data, exp_addr;
        logic [63:0] exp_wdata, lane_mask;
        logic [7:0] exp_strb;
        size = op_size(op);
        cached = addr[31];
        set = addr[6:3];
        tag = addr[63:7];
        is_load = (op >= OP_LB) && (op <= OP_LWU);
        is_store = op >= OP_SB;
        hit = 1'b0;
        victim = -1;
        for (int w = 3; w >= 0; w--) begin
            if (m_valid[set][w] && m_tag[set][w] == tag) hit = 1'b1;
            if (!m_valid[set][w]) victim = w;
        end
        if (cached && is_load && !hit) begin
            if (victim < 0) victim = 0;
            m_valid[set][victim] = 1'b1;
            m_tag[set][victim] = tag;
        end
        word = '0;
        for (int i = 0; i < (1 << size); i++) begin
            word[8*i +: 8] = read_byte(addr + i);
        end
        case (op)
            OP_LB:   exp_data = {{56{word[7]}}, word[7:0]};
            OP_LH:   exp_data = {{48{word[15]}}, word[15:0]};
            OP_LW:   exp_data = {{32{word[31]}}, word[31:0]};
            default: exp_data = word;
        endcase
        exp_addr = cached ? {addr[63:3], 3'b000} : addr;
        exp_strb = 8'(((1 << (1 << size)) - 1) << addr[2:0]);
        // Store bytes land in the lanes starting at the address offset
        exp_wdata = '0;
        lane_mask = '0;
        for (int i = 0; i < (1 << size); i++) begin
            exp_wdata[8*(addr[2:0] + i) +: 8] = wdata[8*i +: 8];
            lane_mask[8*(addr[2:0] + i) +: 8] = 8'hff;
        end
        ar0 = ar_count;
        aw0 = aw_count;
        b0 = b_count;

        @(posedge clk);
        req_valid <= 1'b1;
        req_op <= op;
        req_addr <= addr;
        req_wdata <= wdata;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!resp_valid);
        req_valid <= 1'b0;

        if (is_load) begin
            assert (resp_data == exp_data) else begin
                $display("Fail resp_data: addr %h got %h expected %h", addr, resp_data, exp_data);
                data_errors++;
            end
            assert (ar_count - ar0 == ((cached && hit) ? 0 : 1)) else begin
                $display("Wrong number of read address transfers for load at %h", addr);
                proto_errors++;
            end
            if (!(cached && hit)) begin
                assert (ar_addr_seen == exp_addr) else begin
                    $display("Fail ar_addr: got %h expected %h", ar_addr_seen, exp_addr);
                    data_errors++;
                end
                assert (ar_size_seen == (cached ? 3'd3 : 3'(size))) else begin
                    $display("Fail ar_size: got %h expected %h", ar_size_seen,
                             cached ? 3 : size);
                    data_errors++;
                end
            end
            // Response two cycles after the hit is first seen
            if (cached && hit) begin
                assert (cycles == 3) else begin
                    $display("Cached hit at %h took %0d cycles instead of 2", addr, cycles - 1);
                    proto_errors++;
                end
            end
        end else if (is_store) begin
            assert (aw_count - aw0 == 1 && b_count - b0 == 1) else begin
                $display("Store at %h answered without its write and response", addr);
                proto_errors++;
            end
            assert (aw_addr_seen == exp_addr) else begin
                $display("Fail aw_addr: got %h expected %h", aw_addr_seen, exp_addr);
                data_errors++;
            end
            assert (aw_size_seen == (cached ? 3'd3 : 3'(size))) else begin
                $display("Fail aw_size: got %h expected %h", aw_size_seen, cached ? 3 : size);
                data_errors++;
            end
            assert (w_strb_seen == exp_strb) else begin
                $display("Fail w_strb: got %h expected %h", w_strb_seen, exp_strb);
                data_errors++;
            end
            assert ((w_data_seen & lane_mask) == exp_wdata) else begin
                $display("Fail w_data: got %h expected %h", w_data_seen & lane_mask,
                         exp_wdata);
                data_errors++;
            end
        end else begin
            assert (cycles == 1) else begin
                $display("NOP response was not immediate");
                proto_errors++;
            end
        end
    endtask

    initial begin
        mem_op_e op;
        logic [63:0] addr;
        logic [63:0] wdata;
        int size;
        rst = 1'b1;
        req_valid = 1'b0;
        req_op = OP_NOP;
        req_addr = '0;
        req_wdata = '0;
        for (int s = 0; s < 16; s++) begin
            for (int w = 0; w < 4; w++) begin
                m_valid[s][w] = 1'b0;
                m_tag[s][w] = '0;
            end
        end
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        assert (!ar_valid && !aw_valid && !w_valid && !r_ready && !b_ready && !resp_valid)
        else begin
            $display("A control output is high after reset");
            proto_errors++;
        end

        // Five tags into set 9 push out way 0, then its tag misses again
        for (int t = 0; t < 5; t++) begin
            run_request(OP_LD, 64'h8000_0400 | (64'(t) << 7) | (64'd9 << 3), '0);
        end
        run_request(OP_LD, 64'h8000_0448, '0);

        for (int n = 0; n < NUM_REQ; n++) begin
            op = mem_op_e'(stim_bits(4) % 12);
            size = op_size(op);
            addr = (64'(stim_bits(1)) << 31) | 64'h400 | (64'(stim_bits(3) % 6) << 7)
                   | (64'(stim_bits(2)) << 3) | 64'(stim_bits(3) & ~((1 << size) - 1));
            wdata = {32'(stim_bits(32)), 32'(stim_bits(32))};
            run_request(op, addr, wdata);
            if (addr[31] && op >= OP_SB) begin
                run_request(OP_LD, {addr[63:3], 3'b000}, '0);
            end else if (addr[31] && op != OP_NOP && stim_bits(1) == 1) begin
                run_request(op, addr, wdata);
            end
        end

        @(posedge clk);
        $display("Errors: %0d value, %0d protocol", data_errors, proto_errors);
        if (data_errors + proto_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
